// ==== valu.f ====
source/vec_word_pkg.sv
source/valu_insn_pkg.sv
source/valu_insn_queue.sv
source/valu_operand_stage.sv
source/valu_byte_slice.sv
source/valu_result_queue.sv
source/valu_top.sv
verification/valu_tb_clock.sv
verification/valu_tb.sv

// ==== Bender.yml ====
package:
  name: valu

sources:
  - source/vec_word_pkg.sv
  - source/valu_insn_pkg.sv
  - source/valu_insn_queue.sv
  - source/valu_operand_stage.sv
  - source/valu_byte_slice.sv
  - source/valu_result_queue.sv
  - source/valu_top.sv
  - target: test
    files:
      - verification/valu_tb_clock.sv
      - verification/valu_tb.sv

// ==== verification/valu_tb.sv ====
// Vector ALU testbench
// Table of instructions run against a reference model with random stalls

`timescale 1ns/1ns
`default_nettype none

module valu_tb;

  import vec_word_pkg::*;
  import valu_insn_pkg::*;

  localparam int unsigned ClkPeriod      = 8;
  // Sample one ns before the rising edge
  localparam int unsigned SampleDelay    = ClkPeriod / 2 - 1;
  // Worst cycles per word under stalls, plus slack for reset and drain
  localparam int unsigned WordCycleLimit = 20;
  localparam int unsigned CycleMargin    = 100;

  // One table row
  typedef struct packed {
    alu_op_e op;
    vew_e    vew;
    vlen_t   vl;
    logic    vm;
    logic    use_scalar;
    elen_t   scalar;
    logic    stall;
  } tb_case_t;

  logic                clk_i;
  logic                rst_ni;
  valu_insn_t          insn_i;
  logic                insn_valid_i;
  logic                insn_ready_o;
  elen_t [1:0]         operand_i;
  logic [1:0]          operand_valid_i;
  logic [1:0]          operand_ready_o;
  strb_t               mask_i;
  logic                mask_valid_i;
  logic                mask_ready_o;
  logic                result_req_o;
  valu_payload_t       result_o;
  logic                result_gnt_i;
  logic [NrVInsn-1:0]  insn_done_o;

  // Table, operand streams and expected results
  tb_case_t      case_q [$];
  string         name_q [$];
  elen_t         vs2_q [$];
  elen_t         vs1_q [$];
  strb_t         mask_q [$];
  valu_payload_t exp_q [$];
  logic          exp_last_q [$];
  int            exp_case_q [$];
  logic [31:0]   rng;

  valu_tb_clock #(
    .PeriodNs    (ClkPeriod),
    .ResetCycles (5)
  ) i_clock (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  valu_top UUT (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .insn_i          (insn_i),
    .insn_valid_i    (insn_valid_i),
    .insn_ready_o    (insn_ready_o),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .mask_i          (mask_i),
    .mask_valid_i    (mask_valid_i),
    .mask_ready_o    (mask_ready_o),
    .result_req_o    (result_req_o),
    .result_o        (result_o),
    .result_gnt_i    (result_gnt_i),
    .insn_done_o     (insn_done_o)
  );

  ////////////////////////////////////////////////////////////
  // Random numbers

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  ////////////////////////////////////////////////////////////
  // Checks

  task automatic stop_run();
    $display("** FAIL **");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_payload(input string name, input valu_payload_t exp,
                               input valu_payload_t act);
    elen_t keep;
    for (int b = 0; b < StrbBits; b++) begin
      keep[8*b +: 8] = {8{exp.be[b]}};
    end
    // Data is only defined in enabled bytes
    if (act.id !== exp.id || act.addr !== exp.addr || act.be !== exp.be
        || ((act.wdata ^ exp.wdata) & keep) !== '0) begin
      $display("FAILED %s: result expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_done(input string name, input logic [NrVInsn-1:0] exp,
                            input logic [NrVInsn-1:0] act);
    if (act !== exp) begin
      $display("FAILED %s: insn_done expected %b actual %b", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s: expected %b actual %b", name, exp, act);
      stop_run();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Table and reference model

  task automatic add_case(input string name, input alu_op_e op, input vew_e vew,
                          input int vl, input logic vm, input logic use_scalar,
                          input elen_t scalar, input logic stall);
    tb_case_t c;
    c.op         = op;
    c.vew        = vew;
    c.vl         = vlen_t'(vl);
    c.vm         = vm;
    c.use_scalar = use_scalar;
    c.scalar     = scalar;
    c.stall      = stall;
    case_q.push_back(c);
    name_q.push_back(name);
  endtask

  function automatic valu_insn_t make_insn(input int idx);
    valu_insn_t insn;
    insn.id         = vid_t'(idx);
    insn.op         = case_q[idx].op;
    insn.vew        = case_q[idx].vew;
    insn.vl         = case_q[idx].vl;
    insn.vm         = case_q[idx].vm;
    insn.use_scalar = case_q[idx].use_scalar;
    insn.scalar     = case_q[idx].scalar;
    insn.vd_addr    = vaddr_t'(16 * idx + 3);
    return insn;
  endfunction

  // Draws the operand words of one instruction and its expected payloads
  task automatic build_expected(input int idx);
    tb_case_t      c;
    valu_payload_t p;
    elen_t         vs2;
    elen_t         vs1;
    strb_t         mask;
    elen_t         wmask;
    logic [63:0]   x;
    logic [63:0]   y;
    logic [63:0]   r;
    int            ebits;
    int            epw;
    int            nwords;
    int            nact;
    c      = case_q[idx];
    ebits  = 8 << c.vew;
    epw    = 64 / ebits;
    wmask  = (ebits == 64) ? '1 : ((64'd1 << ebits) - 1);
    nwords = (int'(c.vl) + epw - 1) / epw;
    for (int w = 0; w < nwords; w++) begin
      vs2 = {next_rand(), 32'd0};
      vs2 = vs2 | elen_t'(next_rand());
      vs2_q.push_back(vs2);
      if (c.use_scalar) begin
        // Low scalar element in every slot
        vs1 = '0;
        for (int e = 0; e < epw; e++) begin
          vs1 = vs1 | ((c.scalar & wmask) << (e * ebits));
        end
      end else begin
        vs1 = {next_rand(), 32'd0};
        vs1 = vs1 | elen_t'(next_rand());
        vs1_q.push_back(vs1);
      end
      if (c.vm) begin
        mask = '1;
      end else begin
        mask = strb_t'(next_rand());
        mask_q.push_back(mask);
      end
      nact   = (int'(c.vl) - w * epw < epw) ? int'(c.vl) - w * epw : epw;
      p      = '0;
      p.id   = vid_t'(idx);
      p.addr = vaddr_t'(16 * idx + 3 + w);
      // Element-wise arithmetic, wraps inside each element
      for (int e = 0; e < epw; e++) begin
        x = (vs2 >> (e * ebits)) & wmask;
        y = (vs1 >> (e * ebits)) & wmask;
        case (c.op)
          ADD:     r = x + y;
          SUB:     r = x - y;
          RSUB:    r = y - x;
          AND:     r = x & y;
          OR:      r = x | y;
          XOR:     r = x ^ y;
          default: r = '0;
        endcase
        p.wdata = p.wdata | ((r & wmask) << (e * ebits));
      end
      for (int b = 0; b < StrbBits; b++) begin
        // Merge picks vs1 bytes where the mask is set
        if (c.op == MERGE) begin
          p.wdata[8*b +: 8] = mask[b] ? vs1[8*b +: 8] : vs2[8*b +: 8];
        end
        p.be[b] = (b / (ebits / 8) < nact) && (c.vm || c.op == MERGE || mask[b]);
      end
      exp_q.push_back(p);
      exp_last_q.push_back(w == nwords - 1);
      exp_case_q.push_back(idx);
    end
  endtask

  task automatic load_table();
    add_case("add_ew8",         ADD,   EW8,  16, 1'b1, 1'b0, '0, 1'b0);
    add_case("sub_ew16",        SUB,   EW16,  8, 1'b1, 1'b0, '0, 1'b0);
    add_case("rsub_ew32_tail",  RSUB,  EW32,  5, 1'b1, 1'b0, '0, 1'b0);
    add_case("add_ew64",        ADD,   EW64,  3, 1'b1, 1'b0, '0, 1'b0);
    add_case("sub_ew8_tail",    SUB,   EW8,  13, 1'b1, 1'b0, '0, 1'b0);
    add_case("add_carry_break", ADD,   EW8,  16, 1'b1, 1'b1, 64'h11223344556677ff, 1'b0);
    add_case("and_scalar_ew8",  AND,   EW8,   8, 1'b1, 1'b1, 64'h0123456789abcd5a, 1'b0);
    add_case("or_scalar_ew16",  OR,    EW16,  6, 1'b1, 1'b1, 64'hfedcba9876548421, 1'b0);
    add_case("xor_scalar_ew32", XOR,   EW32,  4, 1'b1, 1'b1, 64'h00ff00ffc3a5f00f, 1'b0);
    add_case("add_masked_ew16", ADD,   EW16,  9, 1'b0, 1'b0, '0, 1'b0);
    add_case("merge_ew8",       MERGE, EW8,  20, 1'b0, 1'b0, '0, 1'b0);
    add_case("merge_ew32_stall", MERGE, EW32, 7, 1'b0, 1'b0, '0, 1'b1);
    add_case("sub_scalar_ew64", SUB,   EW64,  4, 1'b0, 1'b1, 64'h8000000000000001, 1'b1);
    add_case("add_ew8_stall",   ADD,   EW8,  24, 1'b1, 1'b0, '0, 1'b1);
    add_case("rsub_masked_ew16", RSUB, EW16, 10, 1'b0, 1'b0, '0, 1'b1);
    add_case("xor_ew64",        XOR,   EW64,  2, 1'b1, 1'b0, '0, 1'b1);
    add_case("and_ew32_single", AND,   EW32,  1, 1'b1, 1'b0, '0, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus and checking

  initial begin
    int                 insn_idx;
    int                 vs2_idx;
    int                 vs1_idx;
    int                 mask_idx;
    int                 outstanding;
    int                 res_occ;
    int                 cycle_cnt;
    int                 cycle_limit;
    logic [31:0]        r;
    logic [NrVInsn-1:0] exp_done;
    string              head_name;

    insn_i          = '0;
    insn_valid_i    = 1'b0;
    operand_i       = '0;
    operand_valid_i = '0;
    mask_i          = '0;
    mask_valid_i    = 1'b0;
    result_gnt_i    = 1'b0;
    rng             = 32'h62a5;
    insn_idx        = 0;
    vs2_idx         = 0;
    vs1_idx         = 0;
    mask_idx        = 0;
    outstanding     = 0;
    res_occ         = 0;
    cycle_cnt       = 0;

    load_table();
    foreach (case_q[i]) begin
      build_expected(i);
    end
    cycle_limit = exp_q.size() * WordCycleLimit + CycleMargin;

    // Idle outputs after reset
    @(posedge rst_ni);
    @(negedge clk_i);
    #(SampleDelay);
    check_flag("reset insn_ready", 1'b1, insn_ready_o);
    check_flag("reset vs2 ready", 1'b0, operand_ready_o[1]);
    check_flag("reset vs1 ready", 1'b0, operand_ready_o[0]);
    check_flag("reset mask ready", 1'b0, mask_ready_o);
    check_flag("reset result_req", 1'b0, result_req_o);
    check_done("reset", '0, insn_done_o);

    while (insn_idx < case_q.size() || exp_q.size() != 0) begin
      @(negedge clk_i);
      r = next_rand();
      // Instructions offered back to back
      insn_valid_i = insn_idx < case_q.size();
      insn_i       = insn_valid_i ? make_insn(insn_idx) : '0;
      // Operand words with random gaps
      operand_valid_i[1] = (vs2_idx < vs2_q.size()) && (r[1:0] != 2'd0);
      operand_i[1]       = (vs2_idx < vs2_q.size()) ? vs2_q[vs2_idx] : '0;
      operand_valid_i[0] = (vs1_idx < vs1_q.size()) && (r[3:2] != 2'd0);
      operand_i[0]       = (vs1_idx < vs1_q.size()) ? vs1_q[vs1_idx] : '0;
      mask_valid_i       = (mask_idx < mask_q.size()) && (r[5:4] != 2'd0);
      mask_i             = (mask_idx < mask_q.size()) ? mask_q[mask_idx] : '0;
      // Grant only with a request, withheld at random on stall rows
      result_gnt_i = 1'b0;
      if (result_req_o && exp_q.size() != 0) begin
        result_gnt_i = !case_q[exp_case_q[0]].stall || (r[7:6] == 2'd0);
      end

      #(SampleDelay);
      head_name = (exp_q.size() != 0) ? name_q[exp_case_q[0]] : "drain";
      check_flag({head_name, " insn_ready"}, outstanding != InsnQueueDepth, insn_ready_o);
      check_flag({head_name, " result_req"}, res_occ != 0, result_req_o);
      // Full result queue blocks the operand side
      if (res_occ == ResultQueueDepth) begin
        check_flag({head_name, " vs2 ready while full"}, 1'b0, operand_ready_o[1]);
        check_flag({head_name, " vs1 ready while full"}, 1'b0, operand_ready_o[0]);
        check_flag({head_name, " mask ready while full"}, 1'b0, mask_ready_o);
      end

      if (insn_valid_i && insn_ready_o) begin
        insn_idx++;
        outstanding++;
      end
      if (operand_valid_i[1] && operand_ready_o[1]) begin
        vs2_idx++;
        res_occ++;
      end
      if (operand_valid_i[0] && operand_ready_o[0]) begin
        vs1_idx++;
      end
      if (mask_valid_i && mask_ready_o) begin
        mask_idx++;
      end

      exp_done = '0;
      if (result_gnt_i) begin
        check_payload(head_name, exp_q[0], result_o);
        if (exp_last_q[0]) begin
          exp_done[exp_q[0].id] = 1'b1;
          outstanding--;
        end
        exp_q.pop_front();
        exp_last_q.pop_front();
        exp_case_q.pop_front();
        res_occ--;
      end
      check_done(head_name, exp_done, insn_done_o);

      cycle_cnt++;
      if (cycle_cnt > cycle_limit) begin
        $display("Timeout after %0d cycles with %0d result words still expected",
                 cycle_cnt, exp_q.size());
        stop_run();
      end
    end

    if (outstanding != 0 || vs2_idx != vs2_q.size() || vs1_idx != vs1_q.size()
        || mask_idx != mask_q.size()) begin
      $display("Run ended with instructions open or operand words not consumed");
      $display("** FAIL **");
      $fatal(1, "Simulation stopped at the end of the run");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== verification/valu_tb_clock.sv ====
// Testbench clock and reset
// Free-running clock, reset held low for a few cycles and released on a falling edge

`timescale 1ns/1ns
`default_nettype none

module valu_tb_clock #(
  parameter int unsigned PeriodNs    = 8,
  parameter int unsigned ResetCycles = 5
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Release away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// ==== source/valu_top.sv ====
// Vector ALU top level
// Instruction queue, operand stage, eight byte slices and result queue

`timescale 1ns/1ns
`default_nettype none

module valu_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // Instructions
  input  valu_insn_pkg::valu_insn_t         insn_i,
  input  logic                              insn_valid_i,
  output logic                              insn_ready_o,
  // Operand queues, [1] is vs2 and [0] is vs1
  input  vec_word_pkg::elen_t [1:0]         operand_i,
  input  logic [1:0]                        operand_valid_i,
  output logic [1:0]                        operand_ready_o,
  input  vec_word_pkg::strb_t               mask_i,
  input  logic                              mask_valid_i,
  output logic                              mask_ready_o,
  // Register file
  output logic                              result_req_o,
  output valu_insn_pkg::valu_payload_t      result_o,
  input  logic                              result_gnt_i,
  // Finished instruction ids
  output logic [valu_insn_pkg::NrVInsn-1:0] insn_done_o
);

  import vec_word_pkg::*;
  import valu_insn_pkg::*;

  valu_insn_t        issue_insn;
  logic              issue_valid;
  vlen_t             issue_remain;
  logic              issue_fire;
  vlen_t             issue_elems;
  elen_t             slice_a;
  elen_t             slice_b;
  alu_op_e           slice_op;
  strb_t             elem_start;
  strb_t             merge_sel;
  valu_payload_t     res_payload;
  logic              res_valid;
  logic              res_ready;
  elen_t             res_wdata;
  logic              word_commit;
  // Carry chain, nothing enters byte 0
  logic [StrbBits:0] carry;

  valu_insn_queue i_insn_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .insn_i         (insn_i),
    .insn_valid_i   (insn_valid_i),
    .insn_ready_o   (insn_ready_o),
    .issue_insn_o   (issue_insn),
    .issue_valid_o  (issue_valid),
    .issue_remain_o (issue_remain),
    .issue_fire_i   (issue_fire),
    .issue_elems_i  (issue_elems),
    .word_commit_i  (word_commit),
    .insn_done_o    (insn_done_o)
  );

  valu_operand_stage i_operand_stage (
    .issue_insn_i    (issue_insn),
    .issue_valid_i   (issue_valid),
    .issue_remain_i  (issue_remain),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .mask_i          (mask_i),
    .mask_valid_i    (mask_valid_i),
    .mask_ready_o    (mask_ready_o),
    .res_ready_i     (res_ready),
    .issue_fire_o    (issue_fire),
    .issue_elems_o   (issue_elems),
    .slice_a_o       (slice_a),
    .slice_b_o       (slice_b),
    .op_o            (slice_op),
    .elem_start_o    (elem_start),
    .merge_sel_o     (merge_sel),
    .payload_o       (res_payload),
    .res_valid_o     (res_valid)
  );

  assign carry[0] = 1'b0;

  for (genvar i = 0; i < StrbBits; i++) begin : g_slice
    valu_byte_slice i_slice (
      .a_i          (slice_a[8*i +: 8]),
      .b_i          (slice_b[8*i +: 8]),
      .op_i         (slice_op),
      .elem_start_i (elem_start[i]),
      .merge_sel_i  (merge_sel[i]),
      .carry_i      (carry[i]),
      .carry_o      (carry[i+1]),
      .result_o     (res_wdata[8*i +: 8])
    );
  end

  valu_result_queue i_result_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .res_valid_i   (res_valid),
    .payload_i     (res_payload),
    .wdata_i       (res_wdata),
    .res_ready_o   (res_ready),
    .result_req_o  (result_req_o),
    .result_o      (result_o),
    .result_gnt_i  (result_gnt_i),
    .word_commit_o (word_commit)
  );

endmodule

`default_nettype wire

// ==== source/valu_result_queue.sv ====
// Vector ALU result queue
// Buffers finished words and holds the register-file request until grant

`timescale 1ns/1ns
`default_nettype none

module valu_result_queue (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Write side, from the operand stage and slices
  input  logic                         res_valid_i,
  input  valu_insn_pkg::valu_payload_t payload_i,
  input  vec_word_pkg::elen_t          wdata_i,
  output logic                         res_ready_o,
  // Register-file port
  output logic                         result_req_o,
  output valu_insn_pkg::valu_payload_t result_o,
  input  logic                         result_gnt_i,
  // Word written back
  output logic                         word_commit_o
);

  import valu_insn_pkg::*;

  valu_payload_t         queue_q [ResultQueueDepth];
  valu_payload_t         entry;
  logic [ResPntBits-1:0] write_pnt_q;
  logic [ResPntBits-1:0] read_pnt_q;
  logic [ResPntBits:0]   cnt_q;
  logic                  push;
  logic                  pop;

  // Slice bytes fill the data field
  always_comb begin
    entry       = payload_i;
    entry.wdata = wdata_i;
  end

  assign res_ready_o = cnt_q != (ResPntBits+1)'(ResultQueueDepth);
  assign push        = res_valid_i && res_ready_o;

  // Head stays on the port until granted
  assign result_req_o  = cnt_q != '0;
  assign result_o      = queue_q[read_pnt_q];
  assign pop           = result_req_o && result_gnt_i;
  assign word_commit_o = pop;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      write_pnt_q <= '0;
      read_pnt_q  <= '0;
      cnt_q       <= '0;
    end else begin
      if (push) begin
        write_pnt_q <= write_pnt_q + 1'b1;
      end
      if (pop) begin
        read_pnt_q <= read_pnt_q + 1'b1;
      end
      cnt_q <= cnt_q + push - pop;
    end
  end

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      queue_q[write_pnt_q] <= entry;
    end
  end

endmodule

`default_nettype wire

// ==== source/valu_byte_slice.sv ====
// Vector ALU byte slice
// One byte of the SIMD adder and logic unit, carry cut at element starts

`timescale 1ns/1ns
`default_nettype none

module valu_byte_slice (
  input  logic [7:0]             a_i,
  input  logic [7:0]             b_i,
  input  valu_insn_pkg::alu_op_e op_i,
  input  logic                   elem_start_i,
  input  logic                   merge_sel_i,
  input  logic                   carry_i,
  output logic                   carry_o,
  output logic [7:0]             result_o
);

  import valu_insn_pkg::*;

  logic       sub;
  logic       carry_in;
  logic [7:0] b_add;
  logic [7:0] sum;

  // Subtract as a + ~b + 1, the +1 entering at the element start
  assign sub      = op_i inside {SUB, RSUB};
  assign b_add    = sub ? ~b_i : b_i;
  assign carry_in = elem_start_i ? sub : carry_i;

  assign {carry_o, sum} = {1'b0, a_i} + {1'b0, b_add} + {8'd0, carry_in};

  always_comb begin
    unique case (op_i)
      AND:     result_o = a_i & b_i;
      OR:      result_o = a_i | b_i;
      XOR:     result_o = a_i ^ b_i;
      MERGE:   result_o = merge_sel_i ? a_i : b_i;
      default: result_o = sum;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/valu_operand_stage.sv ====
// Vector ALU operand stage
// Joins operands and mask for one word, builds slice controls and the payload

`timescale 1ns/1ns
`default_nettype none

module valu_operand_stage (
  // Issue instruction
  input  valu_insn_pkg::valu_insn_t     issue_insn_i,
  input  logic                          issue_valid_i,
  input  valu_insn_pkg::vlen_t          issue_remain_i,
  // Operand queues, [1] is vs2 and [0] is vs1
  input  vec_word_pkg::elen_t [1:0]     operand_i,
  input  logic [1:0]                    operand_valid_i,
  output logic [1:0]                    operand_ready_o,
  input  vec_word_pkg::strb_t           mask_i,
  input  logic                          mask_valid_i,
  output logic                          mask_ready_o,
  input  logic                          res_ready_i,
  // Back to the instruction queue
  output logic                          issue_fire_o,
  output valu_insn_pkg::vlen_t          issue_elems_o,
  // Slice controls
  output vec_word_pkg::elen_t           slice_a_o,
  output vec_word_pkg::elen_t           slice_b_o,
  output valu_insn_pkg::alu_op_e        op_o,
  output vec_word_pkg::strb_t           elem_start_o,
  output vec_word_pkg::strb_t           merge_sel_o,
  // Result queue write
  output valu_insn_pkg::valu_payload_t  payload_o,
  output logic                          res_valid_o
);

  import vec_word_pkg::*;
  import valu_insn_pkg::*;

  elen_u      scalar_u;
  elen_t      scalar_rep;
  elen_t      vs1;
  elen_t      vs2;
  vlen_t      epw;
  vlen_t      words_done;
  logic [1:0] words_shift;
  logic       swap;
  strb_t      elem_be;

  // Replicate the low scalar element across the word
  always_comb begin
    scalar_u = issue_insn_i.scalar;
    unique case (issue_insn_i.vew)
      EW8:     scalar_rep = {StrbBits{scalar_u.b[0]}};
      EW16:    scalar_rep = {4{scalar_u.h[0]}};
      EW32:    scalar_rep = {2{scalar_u.w[0]}};
      default: scalar_rep = scalar_u.d;
    endcase
  end

  assign vs2 = operand_i[1];
  assign vs1 = issue_insn_i.use_scalar ? scalar_rep : operand_i[0];

  // Fire once every needed input is there and the result queue has room
  assign issue_fire_o = issue_valid_i && res_ready_i && operand_valid_i[1]
                     && (operand_valid_i[0] || issue_insn_i.use_scalar)
                     && (mask_valid_i || issue_insn_i.vm);
  assign operand_ready_o = {issue_fire_o, issue_fire_o && !issue_insn_i.use_scalar};
  assign mask_ready_o    = issue_fire_o && !issue_insn_i.vm;
  assign res_valid_o     = issue_fire_o;

  // Elements in this word, short on the tail
  assign epw           = elems_per_word(issue_insn_i.vew);
  assign issue_elems_o = (issue_remain_i < epw) ? issue_remain_i : epw;

  // RSUB computes vs1 - vs2, MERGE takes vs1 where the mask is set
  assign swap      = issue_insn_i.op inside {RSUB, MERGE};
  assign slice_a_o = swap ? vs1 : vs2;
  assign slice_b_o = swap ? vs2 : vs1;
  assign op_o      = issue_insn_i.op;

  // Element starts and leading active bytes
  always_comb begin
    for (int i = 0; i < StrbBits; i++) begin
      elem_start_o[i] = (i & ((1 << issue_insn_i.vew) - 1)) == 0;
      elem_be[i]      = (i >> issue_insn_i.vew) < issue_elems_o;
    end
  end

  assign merge_sel_o = issue_insn_i.vm ? '1 : mask_i;

  // Words already issued for this instruction
  assign words_shift = 2'(EW64) - issue_insn_i.vew;
  assign words_done  = (issue_insn_i.vl - issue_remain_i) >> words_shift;

  always_comb begin
    payload_o      = '0;
    payload_o.id   = issue_insn_i.id;
    payload_o.addr = issue_insn_i.vd_addr + vaddr_t'(words_done);
    // Mask clears bytes except on MERGE, where it selects
    if (issue_insn_i.vm || issue_insn_i.op == MERGE) begin
      payload_o.be = elem_be;
    end else begin
      payload_o.be = elem_be & mask_i;
    end
  end

endmodule

`default_nettype wire

// ==== source/valu_insn_queue.sv ====
// Vector ALU instruction queue
// Follows each instruction from accept through issue to commit, flags done ids

`timescale 1ns/1ns
`default_nettype none

module valu_insn_queue (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // Instruction port
  input  valu_insn_pkg::valu_insn_t         insn_i,
  input  logic                              insn_valid_i,
  output logic                              insn_ready_o,
  // Issue side, towards the operand stage
  output valu_insn_pkg::valu_insn_t         issue_insn_o,
  output logic                              issue_valid_o,
  output valu_insn_pkg::vlen_t              issue_remain_o,
  input  logic                              issue_fire_i,
  input  valu_insn_pkg::vlen_t              issue_elems_i,
  // Commit side, from the result queue
  input  logic                              word_commit_i,
  output logic [valu_insn_pkg::NrVInsn-1:0] insn_done_o
);

  import valu_insn_pkg::*;

  ////////////////////////////////////////////////////////////
  // Queue state

  valu_insn_t             insn_q [InsnQueueDepth];
  logic [InsnPntBits-1:0] accept_pnt_q;
  logic [InsnPntBits-1:0] issue_pnt_q;
  logic [InsnPntBits-1:0] commit_pnt_q;
  // Instructions waiting to issue and to commit
  logic [InsnPntBits:0]   issue_cnt_q;
  logic [InsnPntBits:0]   commit_cnt_q;
  // Elements already issued or committed for the head instructions
  vlen_t                  issued_q;
  vlen_t                  committed_q;

  valu_insn_t commit_insn;
  vlen_t      commit_remain;
  vlen_t      commit_step;
  logic       accept;
  logic       issue_last;
  logic       commit_last;

  // Full once every slot holds an uncommitted instruction
  assign insn_ready_o = commit_cnt_q != (InsnPntBits+1)'(InsnQueueDepth);
  assign accept       = insn_valid_i && insn_ready_o;

  ////////////////////////////////////////////////////////////
  // Issue and commit heads

  assign issue_insn_o   = insn_q[issue_pnt_q];
  assign issue_valid_o  = issue_cnt_q != '0;
  assign issue_remain_o = issue_insn_o.vl - issued_q;
  // Last word of the issue instruction fires
  assign issue_last     = issue_fire_i && (issue_remain_o == issue_elems_i);

  assign commit_insn   = insn_q[commit_pnt_q];
  assign commit_remain = commit_insn.vl - committed_q;
  assign commit_step   = elems_per_word(commit_insn.vew);
  // Remaining count saturates at zero on a partial last word
  assign commit_last   = word_commit_i && (commit_cnt_q != '0)
                      && (commit_remain <= commit_step);

  // One-cycle done pulse with the grant of the last word
  always_comb begin
    insn_done_o = '0;
    if (commit_last) begin
      insn_done_o[commit_insn.id] = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Registers

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      issued_q     <= '0;
      committed_q  <= '0;
    end else begin
      if (accept) begin
        accept_pnt_q <= accept_pnt_q + 1'b1;
      end
      // Step issue progress, move on after the last word
      if (issue_fire_i) begin
        issued_q <= issue_last ? '0 : issued_q + issue_elems_i;
      end
      if (issue_last) begin
        issue_pnt_q <= issue_pnt_q + 1'b1;
      end
      // Step commit progress, retire on the last word
      if (word_commit_i) begin
        committed_q <= commit_last ? '0 : committed_q + commit_step;
      end
      if (commit_last) begin
        commit_pnt_q <= commit_pnt_q + 1'b1;
      end
      issue_cnt_q  <= issue_cnt_q + accept - issue_last;
      commit_cnt_q <= commit_cnt_q + accept - commit_last;
    end
  end

  // Instruction slots
  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q[accept_pnt_q] <= insn_i;
    end
  end

endmodule

`default_nettype wire

// ==== source/valu_insn_pkg.sv ====
// Vector ALU instruction definitions
// Operation encoding, instruction and result formats, queue sizes

`default_nettype none

package valu_insn_pkg;

  // Instruction ids in flight
  localparam int unsigned NrVInsn          = 8;
  // Element count width
  localparam int unsigned VlenBits         = 11;

  // Queue depths and their pointer widths
  localparam int unsigned InsnQueueDepth   = 4;
  localparam int unsigned InsnPntBits      = $clog2(InsnQueueDepth);
  localparam int unsigned ResultQueueDepth = 2;
  localparam int unsigned ResPntBits       = $clog2(ResultQueueDepth);

  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [VlenBits-1:0]        vlen_t;

  // ALU operations
  typedef enum logic [2:0] {
    ADD,
    SUB,
    RSUB,
    AND,
    OR,
    XOR,
    MERGE
  } alu_op_e;

  // One vector instruction
  typedef struct packed {
    vid_t                 id;
    alu_op_e              op;
    vec_word_pkg::vew_e   vew;
    vlen_t                vl;
    // Set when unmasked
    logic                 vm;
    // Scalar takes the place of vs1
    logic                 use_scalar;
    vec_word_pkg::elen_t  scalar;
    // First word of vd
    vec_word_pkg::vaddr_t vd_addr;
  } valu_insn_t;

  // One result word for the register file
  typedef struct packed {
    vid_t                 id;
    vec_word_pkg::vaddr_t addr;
    vec_word_pkg::elen_t  wdata;
    vec_word_pkg::strb_t  be;
  } valu_payload_t;

  // Elements packed in one word at a given width
  function automatic vlen_t elems_per_word(vec_word_pkg::vew_e vew);
    return vlen_t'(vec_word_pkg::StrbBits >> vew);
  endfunction

endpackage

`default_nettype wire

// ==== source/vec_word_pkg.sv ====
// Vector word definitions
// Element widths, data word, byte-enable and address types of the datapath

`default_nettype none

package vec_word_pkg;

  // Data word width and bytes per word
  localparam int unsigned ElenBits  = 64;
  localparam int unsigned StrbBits  = ElenBits / 8;
  // Register-file word address width
  localparam int unsigned VaddrBits = 12;

  // Element width, encoded like the vtype sew field
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // One data word
  typedef logic [ElenBits-1:0] elen_t;

  // One bit per byte of a word, used for byte enables and masks
  typedef logic [StrbBits-1:0] strb_t;

  // Register-file word address
  typedef logic [VaddrBits-1:0] vaddr_t;

  // Same word seen at each element width
  // Index 0 of every view is the low element
  typedef union packed {
    elen_t                      d;
    logic [1:0][ElenBits/2-1:0] w;
    logic [3:0][ElenBits/4-1:0] h;
    logic [StrbBits-1:0][7:0]   b;
  } elen_u;

endpackage

`default_nettype wire
